// File: transferAck.f
tackPkg.sv
cycleStart.sv
romAckTimer.sv
ciaAckSync.sv
busTimeout.sv
tackDriver.sv
transferAck.sv
tbClockGen.sv
tbTransferAck.sv

// File: Makefile
# Verilator build and run of the transferAck testbench

TOP = tbTransferAck

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f transferAck.f -Mdir obj_dir

# A crashed run is logged as a failure too
run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1 || echo "RESULT: FAIL" >> sim.log
	cat sim.log
	! grep -q "RESULT: FAIL" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tbTransferAck.sv
//////////////////////////////
// Runs one bus cycle at a time, and the DUT must be idle between cycles
// tackInN carries only foreign acknowledges
//////////////////////////////
module tbTransferAck;

    localparam int ROM_DELAY    = 3;
    localparam int TIMEOUT      = 40;
    localparam int RESET_CYCLES = 10;
    localparam int RANDOM_RUNS  = 200;
    // Run body covers the timeout and the full TA sequence
    localparam int RUN_LEN      = TIMEOUT + 8;
    // Gap, alignment to the CIA clock, then the body
    localparam int RUN_MAX      = 8 + 40 + RUN_LEN;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + 3 + (4 + RANDOM_RUNS) * RUN_MAX + 100;

    // Bus cycle kinds
    localparam int KIND_ROM     = 0;
    localparam int KIND_CIA     = 1;
    localparam int KIND_NONE    = 2;
    localparam int KIND_FOREIGN = 3;

    logic CLK80;
    logic DELAYED_TACK_RST;
    logic tsN;
    logic clk40;
    logic romEn;
    logic ciaEnable;
    logic clkCia;
    logic tackInN;
    logic tackOutN;
    logic tackOe;
    logic timeoutEvent;

    int cyc = 0;
    int errors = 0;
    int checks = 0;
    int failedTests = 0;

    tbClockGen #(
        .PERIOD       (100),
        .RESET_CYCLES (RESET_CYCLES)
    ) clockGen0 (
        .CLK80            (CLK80),
        .DELAYED_TACK_RST (DELAYED_TACK_RST)
    );

    transferAck #(
        .romDelay      (tackPkg::romCountT'(ROM_DELAY)),
        .timeoutCycles (tackPkg::timeoutCountT'(TIMEOUT))
    ) dut0 (
        .CLK80            (CLK80),
        .DELAYED_TACK_RST (DELAYED_TACK_RST),
        .tsN              (tsN),
        .clk40            (clk40),
        .romEn            (romEn),
        .ciaEnable        (ciaEnable),
        .clkCia           (clkCia),
        .tackInN          (tackInN),
        .tackOutN         (tackOutN),
        .tackOe           (tackOe),
        .timeoutEvent     (timeoutEvent)
    );

    // Edge count, also bounds the run
    always @(posedge CLK80) begin
        cyc <= cyc + 1;
        if (cyc >= CYCLE_LIMIT) begin
            $display("Run stopped at %0t: cycle limit %0d reached", $time, CYCLE_LIMIT);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    // Next drive point, board clocks follow the edge count
    task automatic tick();
        @(posedge CLK80);
        #1;
        clk40  = cyc[0];
        clkCia = (cyc % 40) >= 20;
    endtask

    task automatic compareBit(string name, logic got, logic exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED at %0t: %s expected %b, got %b", $time, name, exp, got);
        end
    endtask

    task automatic expectOutputs(logic expOutN, logic expOe, logic expEvent);
        compareBit("tackOutN", tackOutN, expOutN);
        compareBit("tackOe", tackOe, expOe);
        compareBit("timeoutEvent", timeoutEvent, expEvent);
    endtask

    // TS needs clk40 high, a CIA cycle also needs its clock phase
    function automatic bit startReady(int kind, int ciaOff);
        if (kind == KIND_CIA) begin
            return (cyc % 40) == 20 + ciaOff;
        end
        return cyc[0] == 1'b1;
    endfunction

    //////////////////////////////
    // One bus cycle against the model
    //////////////////////////////

    task automatic runBusCycle(int kind, int tsHold, int gap, int ciaOff, int foreignAt);
        int s;
        int ackAt;
        int eventAt;
        int fallStep;
        logic expLow;
        logic expOe;
        // Step of the first TA low, -1 for none
        ackAt   = -1;
        eventAt = -1;
        if (kind == KIND_ROM) begin
            ackAt = ROM_DELAY + 2;
        end
        if (kind == KIND_NONE) begin
            eventAt = TIMEOUT + 1;
            ackAt   = TIMEOUT + 2;
        end
        // CIA clock is driven low this many steps after the start
        fallStep = 20 - ciaOff;
        repeat (gap) begin
            tick();
            expectOutputs(1'b1, 1'b0, 1'b0);
        end
        tick();
        while (!startReady(kind, ciaOff)) begin
            expectOutputs(1'b1, 1'b0, 1'b0);
            tick();
        end
        for (s = 0; s < RUN_LEN; s++) begin
            if (s > 0) begin
                tick();
            end
            // CIA ack time is only bounded, fix it when TA shows up
            if (kind == KIND_CIA && ackAt < 0) begin
                if (tackOutN === 1'b0) begin
                    assert (s >= fallStep + 3 && s <= fallStep + 6) else begin
                        errors++;
                        $display("CIA acknowledge at %0t came %0d cycles after the clock fall",
                            $time, s - fallStep);
                    end
                    ackAt = s;
                end else begin
                    assert (s != fallStep + 7) else begin
                        errors++;
                        $display("No CIA acknowledge by %0t after the CIA clock fell", $time);
                    end
                end
            end
            // Two low cycles, one driven high, then release
            expLow = (ackAt >= 0) && (s == ackAt || s == ackAt + 1);
            expOe  = (ackAt >= 0) && (s >= ackAt) && (s <= ackAt + 2);
            expectOutputs(!expLow, expOe, s == eventAt);
            tsN       = (s >= tsHold);
            romEn     = (kind == KIND_ROM) && (s < tsHold);
            ciaEnable = (kind == KIND_CIA) && (ackAt < 0);
            tackInN   = !((kind == KIND_FOREIGN) && (s == foreignAt || s == foreignAt + 1));
        end
        ciaEnable = 1'b0;
    endtask

    task automatic reportTest(string name, int errorsBefore);
        if (errors == errorsBefore) begin
            $display("test %s: ok", name);
        end else begin
            failedTests++;
            $display("test %s: FAILED with %0d errors", name, errors - errorsBefore);
        end
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        int mark;
        int i;
        int kind;
        int hold;
        int gap;
        int off;
        int foreignAt;
        tsN       = 1'b1;
        clk40     = 1'b0;
        romEn     = 1'b0;
        ciaEnable = 1'b0;
        clkCia    = 1'b0;
        tackInN   = 1'b1;
        void'($urandom(67808));

        // Idle outputs through reset and just after release
        mark = errors;
        repeat (RESET_CYCLES + 3) begin
            tick();
            expectOutputs(1'b1, 1'b0, 1'b0);
        end
        reportTest("reset", mark);

        mark = errors;
        runBusCycle(KIND_ROM, 1, 2, 1, 0);
        reportTest("rom", mark);

        mark = errors;
        runBusCycle(KIND_CIA, 1, 2, 7, 0);
        reportTest("cia", mark);

        mark = errors;
        runBusCycle(KIND_NONE, 1, 2, 1, 0);
        reportTest("timeout", mark);

        mark = errors;
        runBusCycle(KIND_FOREIGN, 1, 2, 1, 10);
        reportTest("foreign", mark);

        // Fixed draw order keeps the run repeatable
        mark = errors;
        for (i = 0; i < RANDOM_RUNS; i++) begin
            kind      = $urandom % 4;
            hold      = 1 + $urandom % 4;
            gap       = $urandom % 8;
            off       = 1 + 2 * ($urandom % 7);
            foreignAt = 2 + $urandom % (TIMEOUT - 6);
            runBusCycle(kind, hold, gap, off, foreignAt);
        end
        reportTest("random", mark);

        $display("tests 6, failed %0d, checks %0d, errors %0d", failedTests, checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: tbClockGen.sv
//////////////////////////////
// CLK80 runs from time zero
// Reset is released 1 unit after the last reset edge
//////////////////////////////
module tbClockGen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 10
) (
    output logic CLK80,
    output logic DELAYED_TACK_RST
);

    // Free-running system clock
    initial begin
        CLK80 = 1'b0;
        forever begin
            #(PERIOD / 2);
            CLK80 = ~CLK80;
        end
    end

    // Reset held for a whole number of clock cycles
    initial begin
        DELAYED_TACK_RST = 1'b1;
        repeat (RESET_CYCLES) @(posedge CLK80);
        #1;
        DELAYED_TACK_RST = 1'b0;
    end

endmodule

// File: transferAck.sv
//////////////////////////////
// romEn and ciaEnable come already decoded
// Pad tristate is left to the caller via tackOe
//////////////////////////////
module transferAck #(
    parameter tackPkg::romCountT     romDelay      = tackPkg::ROM_DELAY_DEF,
    parameter tackPkg::timeoutCountT timeoutCycles = tackPkg::TIMEOUT_DEF
) (
    input  logic CLK80,
    input  logic DELAYED_TACK_RST,
    input  logic tsN,
    input  logic clk40,
    input  logic romEn,
    input  logic ciaEnable,
    input  logic clkCia,
    input  logic tackInN,
    output logic tackOutN,
    output logic tackOe,
    output logic timeoutEvent
);

    // Cycle start
    logic startPulse;
    logic romCycle;

    // Acknowledge requests
    logic romAck;
    logic ciaAck;
    logic timeoutAck;

    cycleStart cycleStart0 (
        .CLK80            (CLK80),
        .DELAYED_TACK_RST (DELAYED_TACK_RST),
        .tsN              (tsN),
        .clk40            (clk40),
        .romEn            (romEn),
        .startPulse       (startPulse),
        .romCycle         (romCycle)
    );

    romAckTimer #(
        .romDelay (romDelay)
    ) romAckTimer0 (
        .CLK80            (CLK80),
        .DELAYED_TACK_RST (DELAYED_TACK_RST),
        .startPulse       (startPulse),
        .romCycle         (romCycle),
        .romAck           (romAck)
    );

    ciaAckSync ciaAckSync0 (
        .CLK80            (CLK80),
        .DELAYED_TACK_RST (DELAYED_TACK_RST),
        .ciaEnable        (ciaEnable),
        .clkCia           (clkCia),
        .clk40            (clk40),
        .ciaAck           (ciaAck)
    );

    // Watchdog sees both our drive and the sampled line
    busTimeout #(
        .timeoutCycles (timeoutCycles)
    ) busTimeout0 (
        .CLK80            (CLK80),
        .DELAYED_TACK_RST (DELAYED_TACK_RST),
        .startPulse       (startPulse),
        .tackOutN         (tackOutN),
        .tackInN          (tackInN),
        .timeoutAck       (timeoutAck),
        .timeoutEvent     (timeoutEvent)
    );

    tackDriver tackDriver0 (
        .CLK80            (CLK80),
        .DELAYED_TACK_RST (DELAYED_TACK_RST),
        .romAck           (romAck),
        .ciaAck           (ciaAck),
        .timeoutAck       (timeoutAck),
        .tackOutN         (tackOutN),
        .tackOe           (tackOe)
    );

endmodule

// File: tackDriver.sv
//////////////////////////////
// Requests are taken in idle or in the negate cycle only
// Output feeds a shared open bus line through tackOe
//////////////////////////////
module tackDriver (
    input  logic CLK80,
    input  logic DELAYED_TACK_RST,
    input  logic romAck,
    input  logic ciaAck,
    input  logic timeoutAck,
    output logic tackOutN,
    output logic tackOe
);

    import tackPkg::*;

    drvStateT drvState;

    // Any source may end the bus cycle
    logic ackReq;

    assign ackReq = romAck || ciaAck || timeoutAck;

    //////////////////////////////
    // TA sequence
    //////////////////////////////

    always_ff @(posedge CLK80 or posedge DELAYED_TACK_RST) begin
        if (DELAYED_TACK_RST) begin
            drvState <= DRV_IDLE;
            tackOutN <= 1'b1;
            tackOe   <= 1'b0;
        end else begin
            case (drvState)
                DRV_IDLE, DRV_NEGATE: begin
                    // Line already high in negate, so a new cycle may start
                    if (ackReq) begin
                        drvState <= DRV_ASSERT;
                        tackOutN <= 1'b0;
                        tackOe   <= 1'b1;
                    end else begin
                        drvState <= DRV_IDLE;
                        tackOutN <= 1'b1;
                        tackOe   <= 1'b0;
                    end
                end
                DRV_ASSERT: begin
                    // Second low cycle, late requests dropped
                    drvState <= DRV_HOLD;
                end
                default: begin
                    // Drive high for one cycle before release
                    drvState <= DRV_NEGATE;
                    tackOutN <= 1'b1;
                end
            endcase
        end
    end

    // Never let go of the pad while TA is low
    assert property (@(posedge CLK80) disable iff (DELAYED_TACK_RST)
        (tackOe && !tackOutN) |=> tackOe);

endmodule

// File: busTimeout.sv
//////////////////////////////
// Any low TA on the bus cancels the watchdog
// timeoutCycles counts from the start pulse
//////////////////////////////
module busTimeout #(
    parameter tackPkg::timeoutCountT timeoutCycles = tackPkg::TIMEOUT_DEF
) (
    input  logic CLK80,
    input  logic DELAYED_TACK_RST,
    input  logic startPulse,
    input  logic tackOutN,
    input  logic tackInN,
    output logic timeoutAck,
    output logic timeoutEvent
);

    import tackPkg::*;

    // Zero means idle
    timeoutCountT waitCount;

    // Our own TA or one from another target
    logic busAck;
    logic expired;
    logic fire;

    assign busAck  = !tackOutN || !tackInN;
    assign expired = (waitCount == timeoutCycles) && (waitCount != '0);

    //////////////////////////////
    // Watchdog counter
    //////////////////////////////

    always_ff @(posedge CLK80 or posedge DELAYED_TACK_RST) begin
        if (DELAYED_TACK_RST) begin
            waitCount <= '0;
        end else if (busAck) begin
            // Answered cycle stops the count
            waitCount <= '0;
        end else if (startPulse) begin
            waitCount <= timeoutCountT'(1);
        end else if (expired) begin
            waitCount <= '0;
        end else if (waitCount != '0) begin
            waitCount <= waitCount + timeoutCountT'(1);
        end
    end

    // Late answer in the expiry cycle still wins
    assign fire = expired && !busAck;

    // End the cycle ourselves and log it
    assign timeoutAck   = fire;
    assign timeoutEvent = fire;

endmodule

// File: ciaAckSync.sv
//////////////////////////////
// ciaEnable and clkCia are asynchronous, clk40 is CLK80 derived
// One acknowledge per chip-select period
//////////////////////////////
module ciaAckSync (
    input  logic CLK80,
    input  logic DELAYED_TACK_RST,
    input  logic ciaEnable,
    input  logic clkCia,
    input  logic clk40,
    output logic ciaAck
);

    import tackPkg::*;

    // Two-stage synchronizers, bit 1 is the older sample
    logic [1:0] ciaEnSync;
    logic [1:0] clkCiaSync;

    ciaStateT ciaState;

    //////////////////////////////
    // Input synchronizers
    //////////////////////////////

    always_ff @(posedge CLK80 or posedge DELAYED_TACK_RST) begin
        if (DELAYED_TACK_RST) begin
            ciaEnSync  <= 2'b00;
            clkCiaSync <= 2'b00;
        end else begin
            ciaEnSync  <= {ciaEnSync[0], ciaEnable};
            clkCiaSync <= {clkCiaSync[0], clkCia};
        end
    end

    //////////////////////////////
    // Acknowledge sequence
    //////////////////////////////

    always_ff @(posedge CLK80 or posedge DELAYED_TACK_RST) begin
        if (DELAYED_TACK_RST) begin
            ciaState <= CIA_IDLE;
            ciaAck   <= 1'b0;
        end else begin
            // Request is a single pulse
            ciaAck <= 1'b0;
            case (ciaState)
                CIA_IDLE: begin
                    if (ciaEnSync == 2'b11) begin
                        ciaState <= CIA_WAIT_HIGH;
                    end
                end
                CIA_WAIT_HIGH: begin
                    // Need a full high phase before a falling edge counts
                    if (ciaEnSync == 2'b00) begin
                        ciaState <= CIA_IDLE;
                    end else if (clkCiaSync == 2'b11) begin
                        ciaState <= CIA_WAIT_FALL;
                    end
                end
                CIA_WAIT_FALL: begin
                    if (ciaEnSync == 2'b00) begin
                        ciaState <= CIA_IDLE;
                    end else if (clkCiaSync == 2'b00 && !clk40) begin
                        // Settled low, align to the clk40 low phase
                        ciaAck   <= 1'b1;
                        ciaState <= CIA_DONE;
                    end
                end
                default: begin
                    // Hold until the chip select is released
                    if (ciaEnSync == 2'b00) begin
                        ciaState <= CIA_IDLE;
                    end
                end
            endcase
        end
    end

    // Ack follows a settled low CIA clock
    assert property (@(posedge CLK80) disable iff (DELAYED_TACK_RST)
        ciaAck |-> !clkCiaSync[1]);

endmodule

// File: romAckTimer.sv
//////////////////////////////
// romDelay counts from the start pulse, not from TS
// A new ROM start restarts the delay
//////////////////////////////
module romAckTimer #(
    parameter tackPkg::romCountT romDelay = tackPkg::ROM_DELAY_DEF
) (
    input  logic CLK80,
    input  logic DELAYED_TACK_RST,
    input  logic startPulse,
    input  logic romCycle,
    output logic romAck
);

    import tackPkg::*;

    // Zero means idle, otherwise cycles since the ROM start
    romCountT romCount;

    //////////////////////////////
    // Setup delay counter
    //////////////////////////////

    always_ff @(posedge CLK80 or posedge DELAYED_TACK_RST) begin
        if (DELAYED_TACK_RST) begin
            romCount <= '0;
        end else if (startPulse && romCycle) begin
            // First cycle after the start counts as one
            romCount <= romCountT'(1);
        end else if (romAck) begin
            romCount <= '0;
        end else if (romCount != '0) begin
            romCount <= romCount + romCountT'(1);
        end
    end

    // Request lands exactly romDelay cycles after the start pulse
    assign romAck = (romCount == romDelay) && (romCount != '0);

    // Driver takes one request per bus cycle
    assert property (@(posedge CLK80) disable iff (DELAYED_TACK_RST)
        romAck |=> !romAck);

endmodule

// File: cycleStart.sv
//////////////////////////////
// TS is taken only while clk40 is high
// TS must go high again before the next start
//////////////////////////////
module cycleStart (
    input  logic CLK80,
    input  logic DELAYED_TACK_RST,
    input  logic tsN,
    input  logic clk40,
    input  logic romEn,
    output logic startPulse,
    output logic romCycle
);

    // Set while waiting for a fresh TS assertion
    logic armed;

    always_ff @(posedge CLK80 or posedge DELAYED_TACK_RST) begin
        if (DELAYED_TACK_RST) begin
            armed      <= 1'b1;
            startPulse <= 1'b0;
            romCycle   <= 1'b0;
        end else begin
            // TS low in the clk40-high phase opens a bus cycle
            if (!tsN && clk40 && armed) begin
                startPulse <= 1'b1;
                romCycle   <= romEn;
                armed      <= 1'b0;
            end else begin
                startPulse <= 1'b0;
                // Long TS stays disarmed until released
                if (tsN) begin
                    armed <= 1'b1;
                end
            end
        end
    end

    // One start per TS, even when TS spans several cycles
    assert property (@(posedge CLK80) disable iff (DELAYED_TACK_RST)
        startPulse |=> !startPulse);

endmodule

// File: tackPkg.sv
//////////////////////////////
// romDelay must be 1 to 7 and timeoutCycles 1 to 255
// Zero disables the matching acknowledge source
//////////////////////////////
package tackPkg;

    //////////////////////////////
    // Counter widths
    //////////////////////////////

    // ROM setup delay counter
    typedef logic [2:0] romCountT;

    // Bus watchdog counter
    typedef logic [7:0] timeoutCountT;

    //////////////////////////////
    // State machines
    //////////////////////////////

    // CIA acknowledge sequence, one pass per chip-select period
    typedef enum logic [1:0] {
        CIA_IDLE,
        CIA_WAIT_HIGH,
        CIA_WAIT_FALL,
        CIA_DONE
    } ciaStateT;

    // TA pad sequence, assert two cycles then negate one
    typedef enum logic [1:0] {
        DRV_IDLE,
        DRV_ASSERT,
        DRV_HOLD,
        DRV_NEGATE
    } drvStateT;

    //////////////////////////////
    // Default timing in CLK80 cycles
    //////////////////////////////

    // ROM address setup before the processor latches data
    localparam romCountT ROM_DELAY_DEF = 3'd3;

    // Comfortably longer than the slowest CIA cycle
    localparam timeoutCountT TIMEOUT_DEF = 8'd249;

endpackage
